//--- dv/rv_core_tb.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module rv_core_tb;

	logic                           clk;
	logic                           arst_n_i;
	logic                           imem_we_i;
	logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr_i;
	logic [`XLEN-1:0]               imem_data_i;
	logic                           retire_valid_o;
	logic [`XLEN-1:0]               retire_pc_o;
	logic [`XLEN-1:0]               retire_inst_o;
	logic                           rd_we_o;
	logic [4:0]                     rd_addr_o;
	logic [`XLEN-1:0]               rd_data_o;

	logic [31:0] prog [$];
	logic [31:0] model_mem [`IMEM_DEPTH];
	logic [31:0] model_regs [32];
	logic [31:0] model_pc;
	logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	logic [31:0] w;
	int          seed = 23650;

	rv_core_top rv_core_top_inst (
		.clk            ( clk            ),
		.arst_n_i       ( arst_n_i       ),
		.imem_we_i      ( imem_we_i      ),
		.imem_addr_i    ( imem_addr_i    ),
		.imem_data_i    ( imem_data_i    ),
		.retire_valid_o ( retire_valid_o ),
		.retire_pc_o    ( retire_pc_o    ),
		.retire_inst_o  ( retire_inst_o  ),
		.rd_we_o        ( rd_we_o        ),
		.rd_addr_o      ( rd_addr_o      ),
		.rd_data_o      ( rd_data_o      )
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = {31'd0, $signed(a) < $signed(b)};
			3'd3: r = {31'd0, a < b};
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) r = $signed(a) >>> b[4:0]; // Arithmetic shift keeps the sign.
				else r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// Result packs {rd_we, rd_addr, rd_data, next_pc}.
	function automatic logic [69:0] ref_step(input logic [31:0] pc, input logic [31:0] inst,
		input logic [31:0] regs [32]);
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ii;
		logic [31:0] iu;
		logic [31:0] ib;
		logic [31:0] ij;
		logic [31:0] d;
		logic [31:0] npc;
		logic        we;
		logic        tk;
		opc = inst[6:0];
		f3  = inst[14:12];
		f7  = inst[31:25];
		rd  = inst[11:7];
		a   = regs[inst[19:15]];
		b   = regs[inst[24:20]];
		ii  = {{20{inst[31]}}, inst[31:20]};
		iu  = {inst[31:12], 12'd0};
		ib  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		ij  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		we  = 1'b0;
		d   = 32'd0;
		tk  = 1'b0;
		npc = pc + 32'd4;
		case (opc)
			7'h37: begin
				we = 1'b1;
				d  = iu;
			end
			7'h17: begin
				we = 1'b1;
				d  = pc + iu;
			end
			7'h6f: begin
				we  = 1'b1;
				d   = pc + 32'd4;
				npc = pc + ij;
			end
			7'h67: begin
				if (f3 == 3'd0) begin
					we  = 1'b1;
					d   = pc + 32'd4;
					npc = (a + ii) & ~32'd1;
				end
			end
			7'h63: begin
				case (f3)
					3'd0: tk = a == b;
					3'd1: tk = a != b;
					3'd4: tk = $signed(a) < $signed(b);
					3'd5: tk = $signed(a) >= $signed(b);
					3'd6: tk = a < b;
					3'd7: tk = a >= b;
					default: tk = 1'b0;
				endcase
				if (tk) npc = pc + ib;
			end
			7'h13: begin
				we = (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20);
				d  = alu_ref(f3, f3 == 3'd5 && f7 == 7'h20, a, ii);
			end
			7'h33: begin
				we = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				d  = alu_ref(f3, f7 == 7'h20, a, b);
			end
			default: we = 1'b0;
		endcase
		we = we && rd != 5'd0; // x0 is never written.
		return {we, rd, d, npc};
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			abort_run($sformatf("Fail %s: expected %h, actual %h", what, exp, act));
		end
	endtask

	// Loads prog during reset, then compares n retires against the model.
	task automatic run_program(input string name, input int n);
		logic [69:0] exp;
		logic [31:0] inst;
		int          wait_cnt;
		@(posedge clk);
		#1;
		arst_n_i = 1'b0;
		for (int i = 0; i < prog.size() + 4; i++) begin
			imem_we_i   = i < prog.size();
			imem_addr_i = i[7:0];
			imem_data_i = (i < prog.size()) ? prog[i] : 32'd0;
			if (i < prog.size()) model_mem[i] = prog[i];
			@(negedge clk);
			check_value({name, " reset retire_valid"}, 32'd0, retire_valid_o);
			check_value({name, " reset rd_we"}, 32'd0, rd_we_o);
			@(posedge clk);
			#1;
		end
		imem_we_i = 1'b0;
		arst_n_i  = 1'b1;
		for (int r = 0; r < 32; r++) model_regs[r] = 32'd0;
		model_pc = `RESET_PC;
		wait_cnt = 0;
		while (retire_valid_o !== 1'b1) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > 8) abort_run({name, ": retire_valid_o did not rise after reset"});
		end
		for (int k = 0; k < n; k++) begin
			@(negedge clk); // Outputs are settled half a cycle after the edge.
			inst = model_mem[((model_pc - `RESET_PC) >> 2) % `IMEM_DEPTH];
			exp  = ref_step(model_pc, inst, model_regs);
			check_value({name, " retire_valid"}, 32'd1, retire_valid_o);
			check_value({name, " retire_pc"}, model_pc, retire_pc_o);
			check_value({name, " retire_inst"}, inst, retire_inst_o);
			check_value({name, " rd_we"}, exp[69], rd_we_o);
			check_value({name, " rd_addr"}, exp[68:64], rd_addr_o);
			if (exp[69]) begin
				check_value({name, " rd_data"}, exp[63:32], rd_data_o);
				model_regs[exp[68:64]] = exp[63:32];
			end
			model_pc = exp[31:0];
		end
	endtask

	initial begin
		arst_n_i    = 1'b0;
		imem_we_i   = 1'b0;
		imem_addr_i = '0;
		imem_data_i = '0;

		prog.delete();
		prog.push_back(enc_i(7'h13, 3'd0, 5'd1, 5'd0, 12'hFFB)); // x1 = -5.
		prog.push_back(enc_u(7'h37, 5'd2, 20'h80000));
		prog.push_back(enc_i(7'h13, 3'd0, 5'd3, 5'd0, 12'h007));
		for (int f = 0; f < 8; f++) begin
			prog.push_back(enc_r(7'h00, f[2:0], 5'(4 + f), 5'd1, 5'd3));
			prog.push_back(enc_i(7'h13, f[2:0], 5'(12 + f), 5'd1, 12'hFF9)); // Bad shifts drop.
		end
		prog.push_back(enc_r(7'h20, 3'd0, 5'd20, 5'd1, 5'd3));
		prog.push_back(enc_r(7'h20, 3'd5, 5'd21, 5'd1, 5'd3));
		prog.push_back(enc_r(7'h00, 3'd2, 5'd22, 5'd2, 5'd1));
		prog.push_back(enc_i(7'h13, 3'd1, 5'd23, 5'd3, 12'h01F));
		prog.push_back(enc_i(7'h13, 3'd5, 5'd24, 5'd2, 12'h404));
		prog.push_back(enc_i(7'h13, 3'd5, 5'd25, 5'd2, 12'h004));
		prog.push_back(enc_u(7'h17, 5'd26, 20'hFFFFF));
		prog.push_back(enc_i(7'h13, 3'd0, 5'd0, 5'd1, 12'h005));
		prog.push_back(enc_r(7'h00, 3'd0, 5'd27, 5'd0, 5'd0));
		prog.push_back(32'h0000_0F8B); // Custom opcode with rd = x31.
		prog.push_back(enc_r(7'h01, 3'd0, 5'd28, 5'd1, 5'd3));
		prog.push_back(enc_j(5'd0, 21'd0));
		run_program("alu", prog.size() + 3);

		// Each branch skips a counter increment when it is taken.
		prog.delete();
		prog.push_back(enc_i(7'h13, 3'd0, 5'd1, 5'd0, 12'hFFB));
		prog.push_back(enc_i(7'h13, 3'd0, 5'd3, 5'd0, 12'h007));
		for (int b = 0; b < 6; b++) begin
			prog.push_back(enc_b(br_f3[b], 5'd1, 5'd3, 13'd8));
			prog.push_back(enc_i(7'h13, 3'd0, 5'd5, 5'd5, 12'h001));
			prog.push_back(enc_b(br_f3[b], 5'd3, 5'd1, 13'd8));
			prog.push_back(enc_i(7'h13, 3'd0, 5'd5, 5'd5, 12'h001));
			prog.push_back(enc_b(br_f3[b], 5'd1, 5'd1, 13'd8));
			prog.push_back(enc_i(7'h13, 3'd0, 5'd5, 5'd5, 12'h001));
		end
		prog.push_back(enc_j(5'd6, 21'd8));
		prog.push_back(enc_i(7'h13, 3'd0, 5'd5, 5'd5, 12'h001));
		prog.push_back(enc_u(7'h17, 5'd7, 20'h00000));
		prog.push_back(enc_i(7'h67, 3'd0, 5'd8, 5'd7, 12'h00D)); // Odd target.
		prog.push_back(enc_i(7'h13, 3'd0, 5'd5, 5'd5, 12'h001));
		prog.push_back(enc_j(5'd0, 21'd0));
		run_program("branch_jump", prog.size() + 3);

		prog.delete();
		for (int n = 0; n < 200; n++) begin
			w = $random(seed);
			case (w[1:0])
				2'd0: prog.push_back(enc_r({1'b0, w[2] & (w[5:3] == 3'd0 || w[5:3] == 3'd5), 5'd0},
					w[5:3], w[10:6], w[15:11], w[20:16]));
				2'd1, 2'd2: prog.push_back(enc_i(7'h13, w[5:3], w[10:6], w[15:11],
					(w[4:3] == 2'b01) ? {1'b0, w[2] & w[5], 5'd0, w[20:16]} : w[31:20]));
				default: prog.push_back(enc_u(w[2] ? 7'h37 : 7'h17, w[10:6], w[31:12]));
			endcase
		end
		prog.push_back(enc_j(5'd0, 21'd0));
		run_program("random", prog.size() + 3);

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- hdl/rv_core_pkg.sv
package rv_core_pkg;

	// Operation performed by the ALU in execute.
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLL    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_SLT    = 4'd8,
		ALU_SLTU   = 4'd9,
		ALU_PASS_B = 4'd10 // LUI result is the immediate itself.
	} alu_op_e;

	// Branch condition evaluated on rs1 and rs2.
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LT   = 3'd3,
		BR_GE   = 3'd4,
		BR_LTU  = 3'd5,
		BR_GEU  = 3'd6
	} branch_e;

	typedef enum logic {
		WB_ALU      = 1'b0,
		WB_PC_PLUS4 = 1'b1 // Link value for JAL and JALR.
	} wb_sel_e;

endpackage

//--- hdl/rv_core_top.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module rv_core_top (
	input  logic                           clk,
	input  logic                           arst_n_i,
	input  logic                           imem_we_i,
	input  logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr_i,
	input  logic [`XLEN-1:0]               imem_data_i,
	output logic                           retire_valid_o,
	output logic [`XLEN-1:0]               retire_pc_o,
	output logic [`XLEN-1:0]               retire_inst_o,
	output logic                           rd_we_o,
	output logic [$clog2(`REG_COUNT)-1:0]  rd_addr_o,
	output logic [`XLEN-1:0]               rd_data_o
);

	logic [`XLEN-1:0]              pc;
	logic [`XLEN-1:0]              inst;
	logic [$clog2(`REG_COUNT)-1:0] rs1_addr;
	logic [$clog2(`REG_COUNT)-1:0] rs2_addr;
	logic [$clog2(`REG_COUNT)-1:0] rd_addr;
	logic [`XLEN-1:0]              gpr_rs1;
	logic [`XLEN-1:0]              gpr_rs2;
	logic [`XLEN-1:0]              imm;
	logic [`XLEN-1:0]              op_a;
	logic [`XLEN-1:0]              op_b;
	logic [`XLEN-1:0]              rs1_data;
	logic [`XLEN-1:0]              rs2_data;
	rv_core_pkg::alu_op_e          alu_op;
	rv_core_pkg::branch_e          branch;
	rv_core_pkg::wb_sel_e          wb_sel;
	logic                          is_jal;
	logic                          is_jalr;
	logic                          rd_we;
	logic                          wr_en;
	logic [$clog2(`REG_COUNT)-1:0] wr_addr;
	logic [`XLEN-1:0]              wr_data;
	logic                          jump_en;
	logic [`XLEN-1:0]              jump_addr;

	rv_fetch u_rv_fetch (
		.clk         ( clk         ),
		.arst_n_i    ( arst_n_i    ),
		.jump_en_i   ( jump_en     ),
		.jump_addr_i ( jump_addr   ),
		.imem_we_i   ( imem_we_i   ),
		.imem_addr_i ( imem_addr_i ),
		.imem_data_i ( imem_data_i ),
		.pc_o        ( pc          ),
		.inst_o      ( inst        )
	);

	rv_decode u_rv_decode (
		.pc_i       ( pc       ),
		.inst_i     ( inst     ),
		.rs1_data_i ( gpr_rs1  ),
		.rs2_data_i ( gpr_rs2  ),
		.rs1_addr_o ( rs1_addr ),
		.rs2_addr_o ( rs2_addr ),
		.rd_addr_o  ( rd_addr  ),
		.imm_o      ( imm      ),
		.op_a_o     ( op_a     ),
		.op_b_o     ( op_b     ),
		.rs1_data_o ( rs1_data ),
		.rs2_data_o ( rs2_data ),
		.alu_op_o   ( alu_op   ),
		.branch_o   ( branch   ),
		.wb_sel_o   ( wb_sel   ),
		.is_jal_o   ( is_jal   ),
		.is_jalr_o  ( is_jalr  ),
		.rd_we_o    ( rd_we    )
	);

	rv_regfile u_rv_regfile (
		.clk        ( clk      ),
		.arst_n_i   ( arst_n_i ),
		.rs1_addr_i ( rs1_addr ),
		.rs2_addr_i ( rs2_addr ),
		.wr_en_i    ( wr_en    ),
		.wr_addr_i  ( wr_addr  ),
		.wr_data_i  ( wr_data  ),
		.rs1_data_o ( gpr_rs1  ),
		.rs2_data_o ( gpr_rs2  )
	);

	rv_execute u_rv_execute (
		.pc_i        ( pc        ),
		.op_a_i      ( op_a      ),
		.op_b_i      ( op_b      ),
		.imm_i       ( imm       ),
		.rs1_data_i  ( rs1_data  ),
		.rs2_data_i  ( rs2_data  ),
		.alu_op_i    ( alu_op    ),
		.branch_i    ( branch    ),
		.wb_sel_i    ( wb_sel    ),
		.is_jal_i    ( is_jal    ),
		.is_jalr_i   ( is_jalr   ),
		.rd_addr_i   ( rd_addr   ),
		.rd_we_i     ( rd_we     ),
		.wr_en_o     ( wr_en     ),
		.wr_addr_o   ( wr_addr   ),
		.wr_data_o   ( wr_data   ),
		.jump_en_o   ( jump_en   ),
		.jump_addr_o ( jump_addr )
	);

	// An instruction retires in every cycle the core is out of reset.
	assign retire_valid_o = arst_n_i;
	assign retire_pc_o    = pc;
	assign retire_inst_o  = inst;
	assign rd_we_o        = retire_valid_o & wr_en; // A write only counts for a retired instruction.
	assign rd_addr_o      = wr_addr;
	assign rd_data_o      = wr_data;

endmodule

//--- hdl/rv_decode.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module rv_decode (
	input  logic [`XLEN-1:0]              pc_i,
	input  logic [`XLEN-1:0]              inst_i,
	input  logic [`XLEN-1:0]              rs1_data_i,
	input  logic [`XLEN-1:0]              rs2_data_i,
	output logic [$clog2(`REG_COUNT)-1:0] rs1_addr_o,
	output logic [$clog2(`REG_COUNT)-1:0] rs2_addr_o,
	output logic [$clog2(`REG_COUNT)-1:0] rd_addr_o,
	output logic [`XLEN-1:0]              imm_o,
	output logic [`XLEN-1:0]              op_a_o,
	output logic [`XLEN-1:0]              op_b_o,
	output logic [`XLEN-1:0]              rs1_data_o,
	output logic [`XLEN-1:0]              rs2_data_o,
	output rv_core_pkg::alu_op_e          alu_op_o,
	output rv_core_pkg::branch_e          branch_o,
	output rv_core_pkg::wb_sel_e          wb_sel_o,
	output logic                          is_jal_o,
	output logic                          is_jalr_o,
	output logic                          rd_we_o
);

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	logic [6:0]       opcode;
	logic [2:0]       funct3;
	logic [6:0]       funct7;
	logic [9:0]       funct;
	logic [`XLEN-1:0] imm_i_type;
	logic [`XLEN-1:0] imm_u_type;
	logic [`XLEN-1:0] imm_b_type;
	logic [`XLEN-1:0] imm_j_type;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign funct  = {funct7, funct3};

	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];
	assign rd_addr_o  = inst_i[11:7];

	assign rs1_data_o = rs1_data_i;
	assign rs2_data_o = rs2_data_i;

	assign imm_i_type = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
	assign imm_u_type = {inst_i[31:12], {(`XLEN-20){1'b0}}};
	assign imm_b_type = {{(`XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_j_type = {{(`XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	// Defaults describe a no-op, so any encoding not matched below writes nothing.
	always_comb begin
		alu_op_o  = rv_core_pkg::ALU_ADD;
		branch_o  = rv_core_pkg::BR_NONE;
		wb_sel_o  = rv_core_pkg::WB_ALU;
		is_jal_o  = 1'b0;
		is_jalr_o = 1'b0;
		rd_we_o   = 1'b0;
		imm_o     = '0;
		op_a_o    = rs1_data_i;
		op_b_o    = rs2_data_i;
		case (opcode)
			OPC_LUI: begin
				imm_o    = imm_u_type;
				op_b_o   = imm_u_type;
				alu_op_o = rv_core_pkg::ALU_PASS_B;
				rd_we_o  = 1'b1;
			end
			OPC_AUIPC: begin
				imm_o   = imm_u_type;
				op_a_o  = pc_i;
				op_b_o  = imm_u_type;
				rd_we_o = 1'b1;
			end
			OPC_JAL: begin
				imm_o    = imm_j_type;
				op_a_o   = pc_i;
				op_b_o   = imm_j_type;
				wb_sel_o = rv_core_pkg::WB_PC_PLUS4;
				is_jal_o = 1'b1;
				rd_we_o  = 1'b1;
			end
			OPC_JALR: begin
				if (funct3 == 3'b000) begin
					imm_o     = imm_i_type;
					op_b_o    = imm_i_type;
					wb_sel_o  = rv_core_pkg::WB_PC_PLUS4;
					is_jalr_o = 1'b1;
					rd_we_o   = 1'b1;
				end
			end
			OPC_BRANCH: begin
				imm_o = imm_b_type;
				case (funct3)
					3'b000:  branch_o = rv_core_pkg::BR_EQ;
					3'b001:  branch_o = rv_core_pkg::BR_NE;
					3'b100:  branch_o = rv_core_pkg::BR_LT;
					3'b101:  branch_o = rv_core_pkg::BR_GE;
					3'b110:  branch_o = rv_core_pkg::BR_LTU;
					3'b111:  branch_o = rv_core_pkg::BR_GEU;
					default: branch_o = rv_core_pkg::BR_NONE;
				endcase
			end
			OPC_OP_IMM: begin
				imm_o   = imm_i_type;
				op_b_o  = imm_i_type;
				rd_we_o = 1'b1;
				casez (funct)
					10'b???????_000: alu_op_o = rv_core_pkg::ALU_ADD;
					10'b???????_010: alu_op_o = rv_core_pkg::ALU_SLT;
					10'b???????_011: alu_op_o = rv_core_pkg::ALU_SLTU;
					10'b???????_100: alu_op_o = rv_core_pkg::ALU_XOR;
					10'b???????_110: alu_op_o = rv_core_pkg::ALU_OR;
					10'b???????_111: alu_op_o = rv_core_pkg::ALU_AND;
					10'b0000000_001: alu_op_o = rv_core_pkg::ALU_SLL;
					10'b0000000_101: alu_op_o = rv_core_pkg::ALU_SRL;
					10'b0100000_101: alu_op_o = rv_core_pkg::ALU_SRA;
					default:         rd_we_o  = 1'b0; // Bad shift encoding.
				endcase
			end
			OPC_OP: begin
				rd_we_o = 1'b1;
				case (funct)
					10'b0000000_000: alu_op_o = rv_core_pkg::ALU_ADD;
					10'b0100000_000: alu_op_o = rv_core_pkg::ALU_SUB;
					10'b0000000_001: alu_op_o = rv_core_pkg::ALU_SLL;
					10'b0000000_010: alu_op_o = rv_core_pkg::ALU_SLT;
					10'b0000000_011: alu_op_o = rv_core_pkg::ALU_SLTU;
					10'b0000000_100: alu_op_o = rv_core_pkg::ALU_XOR;
					10'b0000000_101: alu_op_o = rv_core_pkg::ALU_SRL;
					10'b0100000_101: alu_op_o = rv_core_pkg::ALU_SRA;
					10'b0000000_110: alu_op_o = rv_core_pkg::ALU_OR;
					10'b0000000_111: alu_op_o = rv_core_pkg::ALU_AND;
					default:         rd_we_o  = 1'b0;
				endcase
			end
			default: begin
				rd_we_o = 1'b0;
			end
		endcase
	end

endmodule

//--- hdl/rv_execute.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module rv_execute (
	input  logic [`XLEN-1:0]              pc_i,
	input  logic [`XLEN-1:0]              op_a_i,
	input  logic [`XLEN-1:0]              op_b_i,
	input  logic [`XLEN-1:0]              imm_i,
	input  logic [`XLEN-1:0]              rs1_data_i,
	input  logic [`XLEN-1:0]              rs2_data_i,
	input  rv_core_pkg::alu_op_e          alu_op_i,
	input  rv_core_pkg::branch_e          branch_i,
	input  rv_core_pkg::wb_sel_e          wb_sel_i,
	input  logic                          is_jal_i,
	input  logic                          is_jalr_i,
	input  logic [$clog2(`REG_COUNT)-1:0] rd_addr_i,
	input  logic                          rd_we_i,
	output logic                          wr_en_o,
	output logic [$clog2(`REG_COUNT)-1:0] wr_addr_o,
	output logic [`XLEN-1:0]              wr_data_o,
	output logic                          jump_en_o,
	output logic [`XLEN-1:0]              jump_addr_o
);

	localparam int SHAMT_W = $clog2(`XLEN);

	logic [`XLEN-1:0]   alu_res;
	logic [SHAMT_W-1:0] shamt;
	logic [`XLEN-1:0]   pc_plus4;
	logic [`XLEN-1:0]   pc_target;
	logic               br_taken;

	assign shamt = op_b_i[SHAMT_W-1:0];

	always_comb begin
		case (alu_op_i)
			rv_core_pkg::ALU_ADD:    alu_res = op_a_i + op_b_i;
			rv_core_pkg::ALU_SUB:    alu_res = op_a_i - op_b_i;
			rv_core_pkg::ALU_AND:    alu_res = op_a_i & op_b_i;
			rv_core_pkg::ALU_OR:     alu_res = op_a_i | op_b_i;
			rv_core_pkg::ALU_XOR:    alu_res = op_a_i ^ op_b_i;
			rv_core_pkg::ALU_SLL:    alu_res = op_a_i << shamt;
			rv_core_pkg::ALU_SRL:    alu_res = op_a_i >> shamt;
			rv_core_pkg::ALU_SRA:    alu_res = $unsigned($signed(op_a_i) >>> shamt);
			rv_core_pkg::ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
			rv_core_pkg::ALU_SLTU:   alu_res = {{(`XLEN-1){1'b0}}, op_a_i < op_b_i};
			rv_core_pkg::ALU_PASS_B: alu_res = op_b_i;
			default:                 alu_res = '0;
		endcase
	end

	// Branches compare the raw register values, not the ALU operands.
	always_comb begin
		case (branch_i)
			rv_core_pkg::BR_EQ:  br_taken = rs1_data_i == rs2_data_i;
			rv_core_pkg::BR_NE:  br_taken = rs1_data_i != rs2_data_i;
			rv_core_pkg::BR_LT:  br_taken = $signed(rs1_data_i) < $signed(rs2_data_i);
			rv_core_pkg::BR_GE:  br_taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
			rv_core_pkg::BR_LTU: br_taken = rs1_data_i < rs2_data_i;
			rv_core_pkg::BR_GEU: br_taken = rs1_data_i >= rs2_data_i;
			default:             br_taken = 1'b0;
		endcase
	end

	assign pc_plus4  = pc_i + `XLEN'd4;
	assign pc_target = pc_i + imm_i; // Shared by JAL and the conditional branches.

	assign jump_en_o   = is_jal_i | is_jalr_i | br_taken;
	assign jump_addr_o = is_jalr_i ? {alu_res[`XLEN-1:1], 1'b0} : pc_target;

	assign wr_en_o   = rd_we_i && (rd_addr_i != '0);
	assign wr_addr_o = rd_addr_i;
	assign wr_data_o = (wb_sel_i == rv_core_pkg::WB_PC_PLUS4) ? pc_plus4 : alu_res;

endmodule

//--- hdl/rv_fetch.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module rv_fetch (
	input  logic                           clk,
	input  logic                           arst_n_i,
	input  logic                           jump_en_i,
	input  logic [`XLEN-1:0]               jump_addr_i,
	input  logic                           imem_we_i,
	input  logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr_i,
	input  logic [`XLEN-1:0]               imem_data_i,
	output logic [`XLEN-1:0]               pc_o,
	output logic [`XLEN-1:0]               inst_o
);

	localparam int IDX_W = $clog2(`IMEM_DEPTH);

	logic [`XLEN-1:0] imem [`IMEM_DEPTH];
	logic [`XLEN-1:0] pc_offset;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_o <= `RESET_PC;
		end else if (jump_en_i) begin
			pc_o <= jump_addr_i;
		end else begin
			pc_o <= pc_o + `XLEN'd4;
		end
	end

	// The program is only loaded while the core is held in reset.
	always_ff @(posedge clk) begin
		if (imem_we_i && !arst_n_i) begin
			imem[imem_addr_i] <= imem_data_i;
		end
	end

	assign pc_offset = pc_o - `RESET_PC;
	assign inst_o    = imem[pc_offset[IDX_W+1:2]]; // Word index wraps over the memory depth.

	// Jump targets come from execute, so alignment depends on the program as well.
	pc_aligned_a: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		pc_o[1:0] == 2'b00
	);

	no_load_while_running_a: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!imem_we_i
	);

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module rv_regfile (
	input  logic                          clk,
	input  logic                          arst_n_i,
	input  logic [$clog2(`REG_COUNT)-1:0] rs1_addr_i,
	input  logic [$clog2(`REG_COUNT)-1:0] rs2_addr_i,
	input  logic                          wr_en_i,
	input  logic [$clog2(`REG_COUNT)-1:0] wr_addr_i,
	input  logic [`XLEN-1:0]              wr_data_i,
	output logic [`XLEN-1:0]              rs1_data_o,
	output logic [`XLEN-1:0]              rs2_data_o
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && wr_addr_i != '0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// Reads see the value from before a write in the same cycle.
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

	// Execute already drops writes to x0 before they reach this port.
	no_x0_write_a: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!(wr_en_i && wr_addr_i == '0)
	);

endmodule

//--- include/rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Width of the data path and of every address.
`define XLEN 32

// First instruction fetched after reset.
`define RESET_PC 32'h8000_0000

// Architectural registers x0 to x31.
`define REG_COUNT 32

// Instruction memory size in 32-bit words.
`define IMEM_DEPTH 256

`endif

//--- sources.f
+incdir+include
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_core_top.sv
dv/rv_core_tb.sv
